// File: all.f
source/cmd_pkg.sv
source/resp_if.sv
source/reg_if.sv
source/cmd_decoder.sv
source/register_bank.sv
source/resp_fifo.sv
source/tx_streamer.sv
source/cmd_top.sv
test/cmd_model.sv
test/cmd_top_tb.sv

// File: source/cmd_decoder.sv
module cmd_decoder (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [cmd_pkg::DATA_W-1:0] rx_data,
	input  logic                      rx_tvalid,
	input  logic                      rx_tlast,
	output logic                      rx_tready,
	reg_if.decoder                    regs,  // register bank access
	resp_if.source                    resp,  // response words toward the FIFO
	output logic                      idle   // waiting for a new frame
);
	import cmd_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE, S_SERIAL, S_CMD, S_REGNUM, S_WDATA, S_ACCESS,
		S_PUSH_SER, S_PUSH_CMD, S_PUSH_DATA, S_PUSH_TRL, S_ECHO, S_DRAIN
	} state_e;

	state_e            state;
	state_e            state_d;
	logic [DATA_W-1:0] serial_q;     // serial number of the current frame
	logic [DATA_W-1:0] cmd_q;        // command word of the current frame
	logic [DATA_W-1:0] reg_num_q;    // register number operand
	logic [DATA_W-1:0] payload_q;    // write data, then read data
	logic              illegal_q;    // bank flagged the register number
	logic              cmd_last_q;   // command word carried rx_tlast
	logic              frame_done_q; // last operand carried rx_tlast
	logic [CODE_W-1:0] rx_code;      // code field of the word on rx_data
	cmd_code_e         cmd_code;     // code field of the latched command
	logic              rx_accept;

	assign rx_code   = rx_data[CODE_W-1:0];
	assign cmd_code  = cmd_code_e'(cmd_q[CODE_W-1:0]);
	assign rx_accept = rx_tvalid && rx_tready;
	assign idle      = (state == S_IDLE);

	assign regs.reg_num = reg_num_q;
	assign regs.wr_data = payload_q;

	////////////////////
	// next state and outputs
	always_comb begin
		state_d      = state;
		rx_tready    = 1'b0;
		resp.valid   = 1'b0;
		resp.word    = '{data: serial_q, last: 1'b0};
		regs.rd_en   = 1'b0;
		regs.wr_en   = 1'b0;
		case (state)
			S_IDLE: if (rx_tvalid) state_d = S_SERIAL; // a frame is being offered
			S_SERIAL: begin
				rx_tready = 1'b1;
				if (rx_tvalid)
					state_d = rx_tlast ? S_IDLE : S_CMD; // one-word frame has no answer
			end
			S_CMD: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					case (rx_code)
						CC_LOOPBACK: state_d = S_PUSH_SER;
						CC_RD_REG, CC_WR_REG: state_d = rx_tlast ? S_IDLE : S_REGNUM;
						default: state_d = rx_tlast ? S_IDLE : S_DRAIN; // unknown code
					endcase
				end
			end
			S_REGNUM: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					if (cmd_code == CC_WR_REG)
						state_d = rx_tlast ? S_IDLE : S_WDATA; // write without data is dropped
					else
						state_d = S_ACCESS;
				end
			end
			S_WDATA: begin
				rx_tready = 1'b1;
				if (rx_tvalid)
					state_d = S_ACCESS;
			end
			S_ACCESS: begin // single bank cycle
				regs.rd_en = (cmd_code == CC_RD_REG);
				regs.wr_en = (cmd_code == CC_WR_REG);
				state_d    = S_PUSH_SER;
			end
			S_PUSH_SER: begin
				resp.valid = 1'b1;
				if (resp.ready)
					state_d = S_PUSH_CMD;
			end
			S_PUSH_CMD: begin
				resp.valid = 1'b1;
				resp.word  = '{data: cmd_q, last: (cmd_code == CC_LOOPBACK) && cmd_last_q};
				if (resp.ready) begin
					if (cmd_code == CC_LOOPBACK)
						state_d = cmd_last_q ? S_IDLE : S_ECHO;
					else
						state_d = (cmd_code == CC_RD_REG) ? S_PUSH_DATA : S_PUSH_TRL;
				end
			end
			S_PUSH_DATA: begin
				resp.valid = 1'b1;
				resp.word  = '{data: payload_q, last: 1'b0};
				if (resp.ready)
					state_d = S_PUSH_TRL;
			end
			S_PUSH_TRL: begin
				resp.valid = 1'b1;
				resp.word  = '{data: illegal_q ? cmd_q : ~cmd_q, last: 1'b1};
				if (resp.ready)
					state_d = frame_done_q ? S_IDLE : S_DRAIN; // extra words still to come
			end
			S_ECHO: begin // word passes straight from rx into the FIFO
				rx_tready  = resp.ready;
				resp.valid = rx_tvalid;
				resp.word  = '{data: rx_data, last: rx_tlast};
				if (rx_accept && rx_tlast)
					state_d = S_IDLE;
			end
			S_DRAIN: begin
				rx_tready = 1'b1;
				if (rx_tvalid && rx_tlast)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	////////////////////
	// state and frame flags
	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= S_IDLE;
			illegal_q    <= 1'b0;
			cmd_last_q   <= 1'b0;
			frame_done_q <= 1'b0;
		end else begin
			state <= state_d;
			if (rx_accept && state == S_CMD)
				cmd_last_q <= rx_tlast;
			if (rx_accept && (state == S_REGNUM || state == S_WDATA))
				frame_done_q <= rx_tlast;
			if (state == S_ACCESS)
				illegal_q <= regs.illegal;
		end
	end

	// frame words
	always_ff @(posedge clk) begin
		if (rx_accept && state == S_SERIAL)
			serial_q <= rx_data;
		if (rx_accept && state == S_CMD)
			cmd_q <= rx_data;
		if (rx_accept && state == S_REGNUM)
			reg_num_q <= rx_data;
		if (rx_accept && state == S_WDATA)
			payload_q <= rx_data;
		else if (regs.rd_en)
			payload_q <= regs.rd_data; // read result replaces the operand
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(regs.rd_en && regs.wr_en));
	a_resp_hold: assert property (@(posedge clk) disable iff (reset)
		resp.valid && !resp.ready |=> resp.valid);

endmodule

// File: source/cmd_pkg.sv
package cmd_pkg;

	////////////////////
	// stream and field widths
	parameter int DATA_W    = 32; // link word width
	parameter int CODE_W    = 5;  // command code in the low bits of the command word
	parameter int CH_ADDR_W = 3;  // channel address jumpers
	parameter int REG_NUM_W = 8;  // decoded part of the register number operand

	////////////////////
	// command codes

	// anything not listed here is an unknown command and gets drained
	typedef enum logic [CODE_W-1:0] {
		CC_LOOPBACK = 5'd1, // echo every operand back
		CC_RD_REG   = 5'd2, // read one register
		CC_WR_REG   = 5'd3  // write one register
	} cmd_code_e;

	////////////////////
	// one word of a response frame
	typedef struct packed {
		logic [DATA_W-1:0] data; // payload word
		logic              last; // final word of the response
	} resp_word_t;

endpackage

// File: source/cmd_top.sv
module cmd_top #(
	parameter int NUM_REGS   = 8, // 2 to 256
	parameter int FIFO_DEPTH = 4  // response words buffered
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [cmd_pkg::DATA_W-1:0]    rx_data,
	input  logic                         rx_tvalid,
	input  logic                         rx_tlast,
	output logic                         rx_tready,
	output logic [cmd_pkg::DATA_W-1:0]    tx_data,
	output logic                         tx_tvalid,
	output logic                         tx_tlast,
	input  logic                         tx_tready,
	input  logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr,
	output logic                         idle
);

	reg_if  reg_bus ();  // decoder to register bank
	resp_if dec_resp (); // decoder to FIFO
	resp_if tx_resp ();  // FIFO to transmitter

	////////////////////
	// receive side
	cmd_decoder i_cmd_decoder (
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_tvalid (rx_tvalid),
		.rx_tlast  (rx_tlast),
		.rx_tready (rx_tready),
		.regs      (reg_bus.decoder),
		.resp      (dec_resp.source),
		.idle      (idle)
	);

	register_bank #(.NUM_REGS(NUM_REGS)) i_register_bank (
		.clk     (clk),
		.reset   (reset),
		.ch_addr (ch_addr),
		.regs    (reg_bus.bank)
	);

	////////////////////
	// transmit side
	resp_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_resp_fifo (
		.clk   (clk),
		.reset (reset),
		.in    (dec_resp.sink),
		.out   (tx_resp.source)
	);

	tx_streamer i_tx_streamer (
		.clk       (clk),
		.reset     (reset),
		.in        (tx_resp.sink),
		.tx_data   (tx_data),
		.tx_tvalid (tx_tvalid),
		.tx_tlast  (tx_tlast),
		.tx_tready (tx_tready)
	);

endmodule

// File: source/reg_if.sv
// register access port from the command decoder to the register bank
interface reg_if;
	import cmd_pkg::*;

	logic [DATA_W-1:0] reg_num; // full operand word, upper bits must be zero
	logic              wr_en;   // write strobe, takes effect at this edge
	logic              rd_en;   // read strobe, enables rd_data
	logic [DATA_W-1:0] wr_data; // data to store
	logic [DATA_W-1:0] rd_data; // follows reg_num combinationally
	logic              illegal; // reg_num names no register

	modport decoder (
		output reg_num,
		output wr_en,
		output rd_en,
		output wr_data,
		input  rd_data,
		input  illegal
	);

	modport bank (
		input  reg_num,
		input  wr_en,
		input  rd_en,
		input  wr_data,
		output rd_data,
		output illegal
	);

endinterface

// File: source/register_bank.sv
module register_bank #(
	parameter int NUM_REGS = 8 // register 0 plus NUM_REGS-1 r/w registers
) (
	input logic                         clk,
	input logic                         reset,
	input logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr, // raw jumpers
	reg_if.bank                         regs
);
	import cmd_pkg::*;

	logic [DATA_W-1:0]    reg_q [1:NUM_REGS-1]; // read/write registers
	logic [CH_ADDR_W-1:0] ch_addr_q;            // register 0, corrected jumpers
	logic [REG_NUM_W-1:0] reg_idx;
	logic [DATA_W-1:0]    sel_data;

	assign reg_idx = regs.reg_num[REG_NUM_W-1:0];

	// any upper bit set or an index past the bank is illegal
	assign regs.illegal = (regs.reg_num[DATA_W-1:REG_NUM_W] != '0) || (int'(reg_idx) >= NUM_REGS);

	always_comb begin
		if (reg_idx == '0)
			sel_data = DATA_W'(ch_addr_q);
		else
			sel_data = reg_q[reg_idx];
	end
	assign regs.rd_data = (regs.rd_en && !regs.illegal) ? sel_data : '0; // illegal reads as zero

	////////////////////
	// channel address, jumpers 110 belong to channel 011
	always_ff @(posedge clk) begin
		if (reset)
			ch_addr_q <= '0;
		else if (ch_addr == 3'b110)
			ch_addr_q <= 3'b011;
		else
			ch_addr_q <= ch_addr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < NUM_REGS; i++)
				reg_q[i] <= '0;
		end else if (regs.wr_en && !regs.illegal && reg_idx != '0) begin // reg 0 is read-only
			reg_q[reg_idx] <= regs.wr_data;
		end
	end

	for (genvar i = 1; i < NUM_REGS; i++) begin : g_chk
		a_no_illegal_wr: assert property (@(posedge clk) disable iff (reset)
			regs.wr_en && regs.illegal |=> $stable(reg_q[i]));
	end

endmodule

// File: source/resp_fifo.sv
module resp_fifo #(
	parameter int FIFO_DEPTH = 4 // power of two
) (
	input logic    clk,
	input logic    reset,
	resp_if.sink   in,  // from the decoder
	resp_if.source out  // to the transmitter
);
	import cmd_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FIFO_DEPTH);

	resp_word_t       mem [FIFO_DEPTH]; // circular buffer
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;            // words held
	logic             push;
	logic             pop;

	assign in.ready  = (count != FULL_CNT);
	assign out.valid = (count != '0);
	assign out.word  = mem[rd_ptr]; // head word
	assign push      = in.valid && in.ready;
	assign pop       = out.valid && out.ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in.word;
	end

	////////////////////
	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (reset) count <= FULL_CNT);

endmodule

// File: source/resp_if.sv
// response word stream between the decoder, the FIFO and the transmitter
interface resp_if;
	import cmd_pkg::*;

	resp_word_t word;  // held stable from valid until the transfer
	logic       valid; // word is on offer
	logic       ready; // receiver takes the word at this edge

	// side that offers words
	modport source (
		output word,
		output valid,
		input  ready
	);

	// side that takes words
	modport sink (
		input  word,
		input  valid,
		output ready
	);

endinterface

// File: source/tx_streamer.sv
module tx_streamer (
	input  logic                      clk,
	input  logic                      reset,
	resp_if.sink                      in,        // words popped from the FIFO
	output logic [cmd_pkg::DATA_W-1:0] tx_data,
	output logic                      tx_tvalid,
	output logic                      tx_tlast,
	input  logic                      tx_tready
);

	logic load; // stage empty or its word leaves this cycle

	assign load     = !tx_tvalid || tx_tready;
	assign in.ready = load;

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
		end else if (load) begin
			tx_tvalid <= in.valid;
			tx_tlast  <= in.valid && in.word.last;
		end
	end

	always_ff @(posedge clk) begin
		if (load && in.valid)
			tx_data <= in.word.data;
	end

	a_tx_hold: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_data) && $stable(tx_tlast));

endmodule

// File: test/cmd_model.sv
package cmd_model;
	import cmd_pkg::*;

	typedef logic [DATA_W-1:0] word_q_t [$]; // one frame, serial number first

	resp_word_t        expected [$];   // response words still owed on tx
	logic [DATA_W-1:0] reg_copy [256]; // what the bank should hold

	function automatic void clear_model();
		expected.delete();
		for (int i = 0; i < 256; i++)
			reg_copy[i] = '0; // registers come out of reset at zero
	endfunction

	////////////////////
	// jumper strap 110 belongs to channel 011
	function automatic logic [DATA_W-1:0] channel_of(input logic [CH_ADDR_W-1:0] jumpers);
		if (jumpers == 3'b110)
			return DATA_W'(3'b011);
		return DATA_W'(jumpers);
	endfunction

	function automatic void expect_word(input logic [DATA_W-1:0] data, input logic last);
		expected.push_back('{data: data, last: last});
	endfunction

	////////////////////
	// one received frame in, its response words queued out
	function automatic void apply_frame(
		input word_q_t              w,
		input logic [CH_ADDR_W-1:0] jumpers,
		input int                   num_regs
	);
		logic [DATA_W-1:0] cmd;
		logic [DATA_W-1:0] num;
		logic [DATA_W-1:0] rd;
		logic              bad;
		if (w.size() < 2)
			return; // serial number alone, nothing to answer
		cmd = w[1];
		num = (w.size() > 2) ? w[2] : '0;
		bad = (num >= DATA_W'(num_regs)); // any upper bit set lands here too
		case (cmd[CODE_W-1:0])
			CC_LOOPBACK: begin
				expect_word(w[0], 1'b0);
				for (int i = 1; i < w.size(); i++)
					expect_word(w[i], i == w.size() - 1); // echo up to tlast
			end
			CC_RD_REG: begin
				if (w.size() < 3)
					return; // no register number
				if (bad)
					rd = '0;
				else if (num == '0)
					rd = channel_of(jumpers);
				else
					rd = reg_copy[num[REG_NUM_W-1:0]];
				expect_word(w[0], 1'b0);
				expect_word(cmd, 1'b0);
				expect_word(rd, 1'b0);
				expect_word(bad ? cmd : ~cmd, 1'b1); // trailer
			end
			CC_WR_REG: begin
				if (w.size() < 4)
					return; // data word missing
				if (!bad && num != '0)
					reg_copy[num[REG_NUM_W-1:0]] = w[3]; // reg 0 is read-only
				expect_word(w[0], 1'b0);
				expect_word(cmd, 1'b0);
				expect_word(bad ? cmd : ~cmd, 1'b1);
			end
			default: ; // unknown code, drained without answer
		endcase
	endfunction

endpackage

// File: test/cmd_top_tb.sv
module cmd_top_tb;
	import cmd_pkg::*;
	import cmd_model::*;

	localparam int NUM_REGS        = 8;
	localparam int FIFO_DEPTH      = 4;
	localparam int CYCLES_PER_WORD = 40; // watchdog budget per frame word

	// tx_tready patterns
	localparam int READY_RANDOM = 0;
	localparam int READY_HELD   = 1;
	localparam int READY_STALLS = 2;

	logic                 clk;
	logic                 reset;
	logic [DATA_W-1:0]    rx_data;
	logic                 rx_tvalid;
	logic                 rx_tlast;
	logic                 rx_tready;
	logic [DATA_W-1:0]    tx_data;
	logic                 tx_tvalid;
	logic                 tx_tlast;
	logic                 tx_tready;
	logic [CH_ADDR_W-1:0] ch_addr;
	logic                 idle;

	resp_word_t stim [$];          // rx words still to send, last flag = rx_tlast
	string      test_name = "none";
	int         ready_mode = READY_RANDOM;
	int         cycle = 0;
	int         deadline = 0;      // 0 while no test runs
	int         words_accepted = 0;
	int         check_count = 0;
	int         error_count = 0;
	int         test_count = 0;
	int         test_checks = 0;
	int         test_errors = 0;
	bit         driving = 1'b0;
	bit         timed_out;

	cmd_top #(.NUM_REGS(NUM_REGS), .FIFO_DEPTH(FIFO_DEPTH)) i_cmd_top (
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_tvalid (rx_tvalid),
		.rx_tlast  (rx_tlast),
		.rx_tready (rx_tready),
		.tx_data   (tx_data),
		.tx_tvalid (tx_tvalid),
		.tx_tlast  (tx_tlast),
		.tx_tready (tx_tready),
		.ch_addr   (ch_addr),
		.idle      (idle)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// frame builders, each one also feeds the model
	function automatic logic [DATA_W-1:0] cmd_word(input logic [CODE_W-1:0] code);
		logic [DATA_W-1:0] w;
		w = $urandom();
		w[CODE_W-1:0] = code; // upper bits random, must come back unchanged
		return w;
	endfunction

	function automatic logic [DATA_W-1:0] legal_num();
		return DATA_W'($urandom_range(0, NUM_REGS - 1));
	endfunction

	function automatic logic [DATA_W-1:0] illegal_num();
		if ($urandom_range(1) == 0)
			return DATA_W'($urandom_range(NUM_REGS, 255)); // past the bank
		return $urandom() | 32'h100; // upper bits not zero
	endfunction

	function automatic void add_frame(input word_q_t w);
		apply_frame(w, ch_addr, NUM_REGS);
		for (int i = 0; i < w.size(); i++)
			stim.push_back('{data: w[i], last: i == w.size() - 1});
	endfunction

	function automatic void add_loopback(input int n_ops);
		word_q_t w;
		w.push_back($urandom());
		w.push_back(cmd_word(CC_LOOPBACK));
		repeat (n_ops) w.push_back($urandom());
		add_frame(w);
	endfunction

	function automatic void add_read(input logic [DATA_W-1:0] num, input int extra);
		word_q_t w;
		w.push_back($urandom());
		w.push_back(cmd_word(CC_RD_REG));
		w.push_back(num);
		repeat (extra) w.push_back($urandom()); // drained by the DUT
		add_frame(w);
	endfunction

	function automatic void add_write(
		input logic [DATA_W-1:0] num,
		input logic [DATA_W-1:0] data,
		input int                extra
	);
		word_q_t w;
		w.push_back($urandom());
		w.push_back(cmd_word(CC_WR_REG));
		w.push_back(num);
		w.push_back(data);
		repeat (extra) w.push_back($urandom());
		add_frame(w);
	endfunction

	function automatic void add_unknown(input int n_ops);
		word_q_t           w;
		logic [CODE_W-1:0] code;
		code = CODE_W'($urandom_range(4, 31));
		if ($urandom_range(3) == 0)
			code = '0; // zero is unknown as well
		w.push_back($urandom());
		w.push_back(cmd_word(code));
		repeat (n_ops) w.push_back($urandom());
		add_frame(w);
	endfunction

	// rx_tlast before all operands are in
	function automatic void add_truncated();
		word_q_t w;
		int      kind;
		kind = $urandom_range(2);
		w.push_back($urandom());
		if (kind == 1) begin
			w.push_back(cmd_word(($urandom_range(1) == 0) ? CC_RD_REG : CC_WR_REG));
		end else if (kind == 2) begin
			w.push_back(cmd_word(CC_WR_REG));
			w.push_back(legal_num()); // write without its data word
		end
		add_frame(w);
	endfunction

	function automatic void add_random_frame();
		case ($urandom_range(5))
			0: add_loopback($urandom_range(0, 12));
			1: add_read(legal_num(), 0);
			2: add_write(legal_num(), $urandom(), 0);
			3: add_read(illegal_num(), $urandom_range(0, 2));
			4: add_unknown($urandom_range(0, 4));
			default: add_truncated();
		endcase
	endfunction

	////////////////////
	// rx driver, random gaps in rx_tvalid
	task automatic drive_stim();
		resp_word_t w;
		int         gap;
		words_accepted = 0;
		while (stim.size() > 0) begin
			w   = stim.pop_front();
			gap = ($urandom_range(3) == 0) ? $urandom_range(1, 3) : 0;
			repeat (gap) begin
				@(negedge clk);
				rx_tvalid = 1'b0;
			end
			@(negedge clk);
			rx_data   = w.data;
			rx_tlast  = w.last;
			rx_tvalid = 1'b1;
			@(posedge clk);
			while (!rx_tready)
				@(posedge clk); // held until the decoder takes it
			words_accepted++;
		end
		@(negedge clk);
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		driving   = 1'b0;
	endtask

	task automatic set_deadline(input int extra);
		deadline = cycle + stim.size() * CYCLES_PER_WORD + extra + 100;
	endtask

	task automatic wait_responses();
		@(negedge clk);
		while (expected.size() != 0 || !idle)
			@(negedge clk);
		repeat (8) @(negedge clk); // room for a stray word to show up
	endtask

	task automatic run_stim();
		set_deadline(0);
		drive_stim();
		wait_responses();
	endtask

	task automatic check_value(
		input string             name,
		input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want
	);
		check_count++;
		assert (got === want) else begin
			$display("mismatch %s: got %h expected %h (test %s)", name, got, want, test_name);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test();
		test_count++;
		deadline = 0;
		$display("test %-18s %0d checks, %0d errors, %s", test_name,
			check_count - test_checks, error_count - test_errors,
			(error_count == test_errors) ? "passed" : "failed");
	endtask

	////////////////////
	// tx side, ready pattern and response checker
	initial begin
		int stall;
		stall     = 0;
		tx_tready = 1'b0;
		forever begin
			@(negedge clk);
			if (ready_mode == READY_HELD) begin
				tx_tready = 1'b0;
			end else if (ready_mode == READY_RANDOM) begin
				tx_tready = ($urandom_range(3) != 0);
			end else if (stall > 0) begin
				stall--;
				tx_tready = 1'b0;
			end else if ($urandom_range(7) == 0) begin
				stall     = $urandom_range(5, 30); // long stall
				tx_tready = 1'b0;
			end else begin
				tx_tready = 1'b1;
			end
		end
	end

	initial begin
		resp_word_t want;
		forever begin
			@(posedge clk);
			if (!reset && tx_tvalid && tx_tready) begin
				assert (expected.size() > 0) else begin
					$display("response word %h arrived with none expected (test %s)",
						tx_data, test_name);
					error_count++;
				end
				if (expected.size() > 0) begin
					want = expected.pop_front();
					check_value("tx_data", tx_data, want.data);
					check_value("tx_tlast", DATA_W'(tx_tlast), DATA_W'(want.last));
				end
			end
		end
	end

	// watchdog, budget set per test from its word count
	initial begin
		timed_out = 1'b0;
		while (!timed_out) begin
			@(posedge clk);
			cycle++;
			timed_out = (deadline > 0) && (cycle > deadline);
		end
		$display("timeout: test %s stalled with %0d response words outstanding",
			test_name, expected.size());
		$display("TEST FAILED");
		$finish;
	end

	////////////////////
	// test sequence
	initial begin
		logic [CH_ADDR_W-1:0] jumpers;
		void'($urandom(32'hf34dbba0));
		reset     = 1'b1;
		rx_data   = '0;
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		ch_addr   = '0;
		clear_model();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test("after reset");
		@(negedge clk);
		check_value("tx_tvalid", DATA_W'(tx_tvalid), '0);
		check_value("rx_tready", DATA_W'(rx_tready), '0);
		check_value("idle", DATA_W'(idle), DATA_W'(1));
		ch_addr = 3'b110;
		repeat (2) @(negedge clk); // register 0 follows one cycle late
		add_read('0, 0);
		run_stim();
		jumpers = CH_ADDR_W'($urandom_range(0, 6));
		if (jumpers == 3'b110)
			jumpers = 3'b111;
		ch_addr = jumpers;
		repeat (2) @(negedge clk);
		add_read('0, 0);
		run_stim();
		end_test();

		begin_test("loopback");
		repeat (20) add_loopback($urandom_range(0, 10));
		run_stim();
		end_test();

		begin_test("write and read");
		repeat (40) begin
			if ($urandom_range(1) == 0)
				add_write(legal_num(), $urandom(), 0);
			else
				add_read(legal_num(), 0);
		end
		add_write('0, $urandom(), 0); // must not stick
		for (int i = 0; i < NUM_REGS; i++)
			add_read(i, 0);
		run_stim();
		end_test();

		begin_test("illegal and malformed");
		repeat (30) begin
			case ($urandom_range(4))
				0: add_read(illegal_num(), $urandom_range(0, 2));
				1: add_write(illegal_num(), $urandom(), $urandom_range(0, 2));
				2: add_unknown($urandom_range(0, 4));
				3: add_truncated();
				default: add_read(legal_num(), $urandom_range(1, 3)); // extra words
			endcase
			add_loopback($urandom_range(0, 2)); // next frame still answered
		end
		run_stim();
		end_test();

		begin_test("back-pressure");
		ready_mode = READY_HELD;
		add_loopback(16);
		set_deadline(60);
		driving = 1'b1;
		fork
			drive_stim();
		join_none
		repeat (60) @(negedge clk);
		check_count++;
		assert (words_accepted < 18) else begin
			$display("receive stream kept taking words while tx_tready was held low");
			error_count++;
		end
		ready_mode = READY_STALLS;
		while (driving)
			@(negedge clk);
		wait_responses();
		repeat (40) add_random_frame();
		run_stim();
		end_test();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
